// File: all.f
hw/coh_pkg.sv
hw/l1_dcache.sv
hw/coherence_unit.sv
hw/bus_ctrl.sv
hw/cache_coh_system.sv
bench/coh_checks.sv
bench/tb_cache_coherency.sv

// File: bench/coh_checks.sv
module coh_checks (
    input  logic               CLK,
    input  logic               rst_n,
    output logic [1:0]         proc_ren,
    output logic [1:0]         proc_wen,
    output coh_pkg::addr_t     proc_addr [2],
    output coh_pkg::word_t     proc_wdata [2],
    input  logic [1:0]         proc_busy,
    input  coh_pkg::word_t     proc_rdata [2],
    input  coh_pkg::mesi_t     state_transfer [2],
    input  logic               l2_ren,
    input  logic               l2_wen,
    input  coh_pkg::addr_t     l2_addr,
    input  coh_pkg::word_t     l2_store,
    input  coh_pkg::word_t     l2_load,
    input  coh_pkg::l2_state_t l2_state,
    output int                 errors,
    output int                 checks,
    output logic               done
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam coh_pkg::addr_t ADDR_A = 32'h0000_1048;  // Index 1
    localparam coh_pkg::addr_t ADDR_C = 32'h0000_3050;  // Index 2
    localparam coh_pkg::addr_t ADDR_D = 32'h0000_5050;  // Index 2, other tag

    int             value_errors = 0;
    int             hold_errors = 0;
    int             orphan_busy_errors = 0;
    coh_pkg::addr_t beat_addr [$];              // L2 beat log
    logic           beat_write [$];
    coh_pkg::word_t beat_data [$];
    coh_pkg::word_t l2_seen [coh_pkg::addr_t];  // First word the L2 returned
    coh_pkg::word_t written [coh_pkg::addr_t];  // Newest word stored by a core

    assign errors = value_errors + hold_errors + orphan_busy_errors;

    task automatic check_eq(input string name, input coh_pkg::word_t exp,
                            input coh_pkg::word_t act);
        checks++;
        assert (act === exp) else begin
            value_errors++;
            $display("ERROR %s: expected 0x%h, got 0x%h", name, exp, act);
        end
    endtask

    function automatic coh_pkg::word_t expected_word(coh_pkg::addr_t a);
        if (written.exists(a)) return written[a];
        return l2_seen.exists(a) ? l2_seen[a] : 'x;
    endfunction

    function automatic int beats_since(int from, logic write);
        int n = 0;
        for (int i = from; i < beat_addr.size(); i++) begin
            if (beat_write[i] == write) n++;
        end
        return n;
    endfunction

    // Written-back words carry the newest value of their address
    task automatic verify_writebacks(input int from);
        for (int i = from; i < beat_addr.size(); i++) begin
            if (beat_write[i]) check_eq("l2_store", expected_word(beat_addr[i]), beat_data[i]);
        end
    endtask

    // Holds the request until busy is seen low and takes the outputs at the falling edge
    task automatic core_access(input int c, input logic write, input coh_pkg::addr_t a,
                               input coh_pkg::word_t w, output coh_pkg::word_t rd,
                               output coh_pkg::mesi_t st, output int busy_n);
        busy_n = 0;
        @(posedge CLK);
        #1;
        proc_ren[c]   = !write;
        proc_wen[c]   = write;
        proc_addr[c]  = a;
        proc_wdata[c] = w;
        if (write) written[a] = w;
        @(negedge CLK);
        while (proc_busy[c]) begin
            busy_n++;
            @(negedge CLK);
        end
        rd = proc_rdata[c];
        st = state_transfer[c];
        @(posedge CLK);
        #1;
        proc_ren[c] = 1'b0;
        proc_wen[c] = 1'b0;
    endtask

    always @(posedge CLK) begin
        if ((l2_ren || l2_wen) && l2_state == coh_pkg::L2_ACCESS) begin
            beat_addr.push_back(l2_addr);
            beat_write.push_back(l2_wen);
            beat_data.push_back(l2_wen ? l2_store : l2_load);
            if (l2_ren && !l2_seen.exists(l2_addr)) l2_seen[l2_addr] = l2_load;
        end
    end

    // A stalled L2 beat keeps the bus request unchanged
    assert property (@(posedge CLK) disable iff (!rst_n)
                     ((l2_ren || l2_wen) && l2_state != coh_pkg::L2_ACCESS)
                     |=> $stable(l2_ren) && $stable(l2_wen) && $stable(l2_addr) &&
                         (!l2_wen || $stable(l2_store)))
        else begin
            hold_errors++;
            $display("An L2 request changed before the L2 took its beat");
        end

    assert property (@(posedge CLK) disable iff (!rst_n)
                     (proc_busy & ~(proc_ren | proc_wen)) == 2'b00)
        else begin
            orphan_busy_errors++;
            $display("A core was busy with no request held");
        end

    initial begin
        coh_pkg::word_t rd;
        coh_pkg::mesi_t st;
        int             busy_n;
        int             start;
        proc_ren   = '0;
        proc_wen   = '0;
        proc_addr  = '{default: '0};
        proc_wdata = '{default: '0};
        checks     = 0;
        done       = 1'b0;
        repeat (5) begin  // Quiet through reset and just after
            @(negedge CLK);
            check_eq("proc_busy", 0, 32'(proc_busy));
            check_eq("l2_ren", 0, 32'(l2_ren));
            check_eq("l2_wen", 0, 32'(l2_wen));
        end
        // I to E with the peer empty
        start = beat_addr.size();
        core_access(0, 1'b0, ADDR_A, '0, rd, st, busy_n);
        check_eq("state_transfer[0]", 32'(coh_pkg::EXCLUSIVE), 32'(st));
        check_eq("proc_rdata[0]", expected_word(ADDR_A), rd);
        check_eq("l2_ren beats", 2, beats_since(start, 1'b0));
        // Cache to cache sharing leaves both in SHARED
        start = beat_addr.size();
        core_access(1, 1'b0, ADDR_A, '0, rd, st, busy_n);
        check_eq("state_transfer[1]", 32'(coh_pkg::SHARED), 32'(st));
        check_eq("proc_rdata[1]", expected_word(ADDR_A), rd);
        check_eq("l2_ren beats", 0, beats_since(start, 1'b0));
        core_access(0, 1'b0, ADDR_A + 4, '0, rd, st, busy_n);
        check_eq("state_transfer[0]", 32'(coh_pkg::SHARED), 32'(st));
        check_eq("proc_rdata[0]", expected_word(ADDR_A + 4), rd);
        check_eq("proc_busy[0] cycles", 0, busy_n);
        // Upgrade invalidates core 1
        start = beat_addr.size();
        core_access(0, 1'b1, ADDR_A, 32'hc0de_0a0a, rd, st, busy_n);
        check_eq("state_transfer[0]", 32'(coh_pkg::MODIFIED), 32'(st));
        check_eq("l2_ren beats", 0, beats_since(start, 1'b0));
        // Dirty supplier also writes the block back
        start = beat_addr.size();
        core_access(1, 1'b0, ADDR_A, '0, rd, st, busy_n);
        check_eq("state_transfer[1]", 32'(coh_pkg::SHARED), 32'(st));
        check_eq("proc_rdata[1]", expected_word(ADDR_A), rd);
        check_eq("l2_wen beats", 2, beats_since(start, 1'b1));
        verify_writebacks(start);
        // Silent E to M
        core_access(0, 1'b0, ADDR_C, '0, rd, st, busy_n);
        check_eq("state_transfer[0]", 32'(coh_pkg::EXCLUSIVE), 32'(st));
        start = beat_addr.size();
        core_access(0, 1'b1, ADDR_C + 4, 32'h5eed_c0c0, rd, st, busy_n);
        check_eq("proc_busy[0] cycles", 0, busy_n);
        check_eq("state_transfer[0]", 32'(coh_pkg::MODIFIED), 32'(st));
        check_eq("l2 beats", 0, beat_addr.size() - start);
        // Evicting the M line sends the old block out before the fill
        start = beat_addr.size();
        core_access(0, 1'b0, ADDR_D, '0, rd, st, busy_n);
        check_eq("state_transfer[0]", 32'(coh_pkg::EXCLUSIVE), 32'(st));
        check_eq("proc_rdata[0]", expected_word(ADDR_D), rd);
        check_eq("l2 beats", 4, beat_addr.size() - start);
        verify_writebacks(start);
        for (int i = 0; i < 4 && start + i < beat_addr.size(); i++) begin
            check_eq("l2_wen", 32'(i < 2), 32'(beat_write[start + i]));
            check_eq("l2_addr", (i < 2 ? ADDR_C : ADDR_D) + 32'(4 * (i % 2)),
                     beat_addr[start + i]);
        end
        done = 1'b1;
    end

endmodule

// File: bench/tb_cache_coherency.sv
module tb_cache_coherency;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_LINES   = 8;
    localparam int CYCLE_LIMIT = 2000;  // About four times the longest sequence with L2 stalls

    logic                 CLK;
    logic                 rst_n;
    logic [1:0]           proc_ren;
    logic [1:0]           proc_wen;
    coh_pkg::addr_t       proc_addr [2];
    coh_pkg::word_t       proc_wdata [2];
    logic [1:0]           proc_busy;
    coh_pkg::word_t       proc_rdata [2];
    coh_pkg::mesi_t       state_transfer [2];
    logic                 l2_ren;
    logic                 l2_wen;
    coh_pkg::addr_t       l2_addr;
    coh_pkg::word_t       l2_store;
    coh_pkg::word_t       l2_load;
    coh_pkg::l2_state_t   l2_state;
    int                   errors;
    int                   checks;
    logic                 done;
    int                   cycles = 0;
    int                   l2_wait = 0;               // Busy cycles left on the current beat
    coh_pkg::word_t       l2_mem [coh_pkg::addr_t];  // Only words written by the bus

    cache_coh_system #(.NUM_LINES(NUM_LINES)) i_cache_coh_system (.*);

    coh_checks i_coh_checks (.*);  // Stimulus and assertions

    // Unwritten words start at a hash of the whole address
    function automatic coh_pkg::word_t fill_word(coh_pkg::addr_t a);
        return {a[15:0], a[31:16]} ^ (a * 32'h9e37_79b1) ^ 32'h2b6f_d043;
    endfunction

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge CLK);
        #1 rst_n = 1'b1;
        wait (done);
        @(posedge CLK);
        $display("Checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycles);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // L2 model with 0 to 3 L2_BUSY cycles before each L2_ACCESS beat
    initial begin
        void'($urandom(32'he5b99b31));  // One seed for the whole run
        l2_state = coh_pkg::L2_FREE;
        l2_load  = '0;
        forever begin
            @(posedge CLK);
            #1;
            if (!(l2_ren || l2_wen)) begin
                l2_state = coh_pkg::L2_FREE;
            end else if (l2_state != coh_pkg::L2_BUSY) begin
                l2_wait  = int'($urandom % 4);  // New beat
                l2_state = coh_pkg::L2_BUSY;
            end
            if (l2_state == coh_pkg::L2_BUSY) begin
                if (l2_wait == 0) begin
                    l2_state = coh_pkg::L2_ACCESS;
                    if (l2_wen) begin
                        l2_mem[l2_addr] = l2_store;
                    end else begin
                        l2_load = l2_mem.exists(l2_addr) ? l2_mem[l2_addr] : fill_word(l2_addr);
                    end
                end else begin
                    l2_wait--;
                end
            end
        end
    end

    // Run limit
    always @(posedge CLK) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run still going after %0d cycles, %0d errors so far",
                     cycles, errors);
            $display("Errors found");
            $finish;
        end
    end

endmodule

// File: hw/bus_ctrl.sv
module bus_ctrl (
    input  logic               CLK,
    input  logic               rst_n,
    // Cache requests, one per core
    input  logic [1:0]         d_ren,
    input  logic [1:0]         d_wen,
    input  logic [1:0]         cc_write,
    input  coh_pkg::addr_t     d_addr [2],
    input  coh_pkg::block_t    d_store [2],
    output logic [1:0]         d_wait,
    output coh_pkg::block_t    d_load [2],
    output logic [1:0]         cc_exclusive,
    // Snoop side
    output coh_pkg::addr_t     cc_snoop_addr [2],
    output logic [1:0]         cc_snoop_req,
    output logic [1:0]         cc_inv,
    input  logic [1:0]         cc_snoop_done,
    input  logic [1:0]         cc_snoop_hit,
    input  logic [1:0]         cc_dirty,
    input  coh_pkg::block_t    snoop_data [2],
    // L2
    output logic               l2_ren,
    output logic               l2_wen,
    output coh_pkg::addr_t     l2_addr,
    output coh_pkg::word_t     l2_store,
    input  coh_pkg::word_t     l2_load,
    input  coh_pkg::l2_state_t l2_state
);

    coh_pkg::bus_state_t state;
    logic                req_id;     // Core that owns the bus
    logic                prio;       // Core that wins a tie
    logic                beat;       // Word of the block on the L2 side
    logic                excl;       // No other sharer seen
    logic                sup_dirty;  // Supplier held the block in M
    coh_pkg::block_t     buf_q;
    logic [1:0]          pend;
    logic                other;
    logic                winner;
    logic                l2_beat_done;

    assign pend   = d_ren | d_wen | cc_write;
    assign other  = ~req_id;
    assign winner = (pend == 2'b11) ? prio : pend[1];
    assign l2_beat_done = (l2_ren || l2_wen) && (l2_state == coh_pkg::L2_ACCESS);

    always_comb begin
        for (int c = 0; c < 2; c++) begin
            d_wait[c]        = !(state == coh_pkg::DONE && req_id == 1'(c));  // Low for 1 cycle
            d_load[c]        = buf_q;
            cc_exclusive[c]  = excl;
            cc_snoop_addr[c] = d_addr[req_id];
            cc_snoop_req[c]  = (state == coh_pkg::SNOOP) && (other == 1'(c));  // Peer only
            cc_inv[c]        = cc_snoop_req[c] && cc_write[req_id];
        end
    end

    assign l2_ren   = (state == coh_pkg::READ_L2);
    assign l2_wen   = (state == coh_pkg::WRITEBACK);
    assign l2_addr  = {d_addr[req_id][31:3], beat, 2'b00};
    assign l2_store = buf_q[32*beat +: 32];

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state     <= coh_pkg::IDLE;
            req_id    <= 1'b0;
            prio      <= 1'b0;  // Core 0 first
            beat      <= 1'b0;
            excl      <= 1'b0;
            sup_dirty <= 1'b0;
        end else begin
            case (state)
                coh_pkg::IDLE: begin
                    if (|pend) begin
                        req_id <= winner;
                        prio   <= ~winner;  // Alternate after each grant
                        state  <= coh_pkg::GRANT;
                    end
                end
                coh_pkg::GRANT: begin
                    beat  <= 1'b0;
                    state <= d_wen[req_id] ? coh_pkg::WRITEBACK : coh_pkg::SNOOP;  // Victim WB
                end
                coh_pkg::SNOOP: begin
                    if (cc_snoop_done[other]) begin
                        sup_dirty <= cc_snoop_hit[other] && cc_dirty[other];
                        excl      <= !cc_snoop_hit[other];
                        if (!d_ren[req_id]) begin
                            state <= coh_pkg::DONE;  // Upgrade moves no data
                        end else if (cc_snoop_hit[other]) begin
                            state <= coh_pkg::TRANSFER;
                        end else begin
                            state <= coh_pkg::READ_L2;
                        end
                    end
                end
                coh_pkg::TRANSFER: begin
                    // Dirty supplier block also goes to L2 so the supplier may hold it in S
                    state <= sup_dirty ? coh_pkg::WRITEBACK : coh_pkg::DONE;
                end
                coh_pkg::READ_L2, coh_pkg::WRITEBACK: begin
                    if (l2_beat_done) begin
                        beat <= ~beat;
                        if (beat) state <= coh_pkg::DONE;
                    end
                end
                default: state <= coh_pkg::IDLE;  // DONE
            endcase
        end
    end

    // Block buffer
    always_ff @(posedge CLK) begin
        if (state == coh_pkg::GRANT) begin
            buf_q <= d_store[req_id];
        end else if (state == coh_pkg::SNOOP && cc_snoop_done[other]) begin
            buf_q <= snoop_data[other];
        end else if (state == coh_pkg::READ_L2 && l2_beat_done) begin
            buf_q[32*beat +: 32] <= l2_load;
        end
    end

endmodule

// File: hw/cache_coh_system.sv
module cache_coh_system #(
    parameter int NUM_LINES = 8
) (
    input  logic               CLK,
    input  logic               rst_n,
    // Cores
    input  logic [1:0]         proc_ren,
    input  logic [1:0]         proc_wen,
    input  coh_pkg::addr_t     proc_addr [2],
    input  coh_pkg::word_t     proc_wdata [2],
    output logic [1:0]         proc_busy,
    output coh_pkg::word_t     proc_rdata [2],
    output coh_pkg::mesi_t     state_transfer [2],
    // L2
    output logic               l2_ren,
    output logic               l2_wen,
    output coh_pkg::addr_t     l2_addr,
    output coh_pkg::word_t     l2_store,
    input  coh_pkg::word_t     l2_load,
    input  coh_pkg::l2_state_t l2_state
);

    localparam int IDX_W = $clog2(NUM_LINES);

    // Cache to coherence unit
    coh_pkg::addr_t   lookup_addr [2];
    coh_pkg::mesi_t   line_state [2];
    logic [1:0]       fill_valid;
    logic [1:0]       fill_exclusive;
    logic [1:0]       fill_write;
    logic [1:0]       write_hit;
    logic [IDX_W-1:0] invalidate_idx [2];
    logic [1:0]       invalidate_strobe;
    coh_pkg::block_t  snoop_block [2];
    // Cache to bus
    logic [1:0]       d_ren;
    logic [1:0]       d_wen;
    logic [1:0]       cc_write;
    coh_pkg::addr_t   d_addr [2];
    coh_pkg::block_t  d_store [2];
    logic [1:0]       d_wait;
    coh_pkg::block_t  d_load [2];
    logic [1:0]       cc_exclusive;
    // Bus to coherence unit
    coh_pkg::addr_t   cc_snoop_addr [2];
    logic [1:0]       cc_snoop_req;
    logic [1:0]       cc_inv;
    logic [1:0]       cc_snoop_done;
    logic [1:0]       cc_snoop_hit;
    logic [1:0]       cc_dirty;
    coh_pkg::block_t  snoop_data [2];

    for (genvar c = 0; c < 2; c++) begin : g_core
        l1_dcache #(.NUM_LINES(NUM_LINES)) i_l1_dcache (
            .CLK(CLK), .rst_n(rst_n),
            .proc_ren(proc_ren[c]), .proc_wen(proc_wen[c]),
            .proc_addr(proc_addr[c]), .proc_wdata(proc_wdata[c]),
            .proc_busy(proc_busy[c]), .proc_rdata(proc_rdata[c]),
            .state_transfer(state_transfer[c]),
            .lookup_addr(lookup_addr[c]), .line_state(line_state[c]),
            .fill_valid(fill_valid[c]), .fill_exclusive(fill_exclusive[c]),
            .fill_write(fill_write[c]), .write_hit(write_hit[c]),
            .invalidate_idx(invalidate_idx[c]), .invalidate_strobe(invalidate_strobe[c]),
            .snoop_addr(cc_snoop_addr[c]), .snoop_block(snoop_block[c]),
            .d_ren(d_ren[c]), .d_wen(d_wen[c]), .cc_write(cc_write[c]),
            .d_addr(d_addr[c]), .d_store(d_store[c]),
            .d_wait(d_wait[c]), .d_load(d_load[c]), .cc_exclusive(cc_exclusive[c])
        );

        coherence_unit #(.NUM_LINES(NUM_LINES)) i_coherence_unit (
            .CLK(CLK), .rst_n(rst_n),
            .lookup_addr(lookup_addr[c]),
            .fill_valid(fill_valid[c]), .fill_exclusive(fill_exclusive[c]),
            .fill_write(fill_write[c]), .write_hit(write_hit[c]),
            .line_state(line_state[c]),
            .invalidate_idx(invalidate_idx[c]), .invalidate_strobe(invalidate_strobe[c]),
            .cc_snoop_addr(cc_snoop_addr[c]), .cc_snoop_req(cc_snoop_req[c]),
            .cc_inv(cc_inv[c]), .cc_snoop_done(cc_snoop_done[c]),
            .cc_snoop_hit(cc_snoop_hit[c]), .cc_dirty(cc_dirty[c]),
            .snoop_data(snoop_data[c]), .cache_block(snoop_block[c])
        );
    end

    // Single serializing point for both cores
    bus_ctrl i_bus_ctrl (.*);

endmodule

// File: hw/coh_pkg.sv
package coh_pkg;

    typedef logic [31:0] word_t;   // One data word
    typedef logic [31:0] addr_t;   // Byte address
    typedef logic [63:0] block_t;  // Two-word block, word 0 in the low half

    // MESI line states
    typedef enum logic [1:0] {
        INVALID,
        SHARED,
        EXCLUSIVE,
        MODIFIED
    } mesi_t;

    // L2 handshake levels
    typedef enum logic [1:0] {
        L2_FREE,    // No request in progress
        L2_BUSY,    // Working on the current beat
        L2_ACCESS   // Beat completes this cycle
    } l2_state_t;

    // Shared bus transaction states
    typedef enum logic [2:0] {
        IDLE,
        GRANT,
        SNOOP,
        TRANSFER,   // Supplier block goes to the requester
        READ_L2,
        WRITEBACK,  // Two beats of a dirty block to L2
        DONE
    } bus_state_t;

endpackage

// File: hw/coherence_unit.sv
module coherence_unit #(
    parameter int NUM_LINES = 8,
    localparam int IDX_W = $clog2(NUM_LINES),
    localparam int TAG_W = 29 - IDX_W
) (
    input  logic             CLK,
    input  logic             rst_n,
    // Cache side
    input  coh_pkg::addr_t   lookup_addr,
    input  logic             fill_valid,
    input  logic             fill_exclusive,
    input  logic             fill_write,
    input  logic             write_hit,
    output coh_pkg::mesi_t   line_state,
    output logic [IDX_W-1:0] invalidate_idx,
    output logic             invalidate_strobe,
    // Snoop side
    input  coh_pkg::addr_t   cc_snoop_addr,
    input  logic             cc_snoop_req,
    input  logic             cc_inv,
    output logic             cc_snoop_done,
    output logic             cc_snoop_hit,
    output logic             cc_dirty,
    output coh_pkg::block_t  snoop_data,
    input  coh_pkg::block_t  cache_block
);

    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [TAG_W-1:0] tag_t;

    coh_pkg::mesi_t state [NUM_LINES];
    tag_t           dup_tag [NUM_LINES];  // Snoop copy of the cache tags
    idx_t           l_idx;
    idx_t           s_idx;
    coh_pkg::mesi_t s_state;
    logic           s_match;
    logic           snoop_now;

    assign l_idx      = lookup_addr[3 +: IDX_W];
    assign s_idx      = cc_snoop_addr[3 +: IDX_W];
    assign line_state = state[l_idx];  // State of the indexed line, tag checked by the cache
    assign s_state    = state[s_idx];
    assign s_match    = (s_state != coh_pkg::INVALID) &&
                        (dup_tag[s_idx] == cc_snoop_addr[31 -: TAG_W]);
    assign snoop_now  = cc_snoop_req && !cc_snoop_done;  // One reply per request

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_LINES; i++) begin
                state[i] <= coh_pkg::INVALID;
            end
            cc_snoop_done     <= 1'b0;
            cc_snoop_hit      <= 1'b0;
            cc_dirty          <= 1'b0;
            invalidate_strobe <= 1'b0;
        end else begin
            cc_snoop_done     <= snoop_now;
            invalidate_strobe <= snoop_now && s_match && cc_inv;
            if (snoop_now) begin
                cc_snoop_hit <= s_match;
                cc_dirty     <= s_match && (s_state == coh_pkg::MODIFIED);
            end
            // Processor side transitions
            if (fill_valid) begin
                if (fill_write) begin
                    state[l_idx] <= coh_pkg::MODIFIED;
                end else if (fill_exclusive) begin
                    state[l_idx] <= coh_pkg::EXCLUSIVE;
                end else begin
                    state[l_idx] <= coh_pkg::SHARED;
                end
            end else if (write_hit) begin
                state[l_idx] <= coh_pkg::MODIFIED;  // Silent E to M
            end
            // Bus side wins on the same line
            if (snoop_now && s_match) begin
                state[s_idx] <= cc_inv ? coh_pkg::INVALID : coh_pkg::SHARED;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (fill_valid) dup_tag[l_idx] <= lookup_addr[31 -: TAG_W];
        if (snoop_now) begin
            invalidate_idx <= s_idx;
            snoop_data     <= cache_block;  // Sampled before any later local write
        end
    end

endmodule

// File: hw/l1_dcache.sv
module l1_dcache #(
    parameter int NUM_LINES = 8,
    localparam int IDX_W = $clog2(NUM_LINES),
    localparam int TAG_W = 29 - IDX_W
) (
    input  logic             CLK,
    input  logic             rst_n,
    // Processor side
    input  logic             proc_ren,
    input  logic             proc_wen,
    input  coh_pkg::addr_t   proc_addr,
    input  coh_pkg::word_t   proc_wdata,
    output logic             proc_busy,
    output coh_pkg::word_t   proc_rdata,
    output coh_pkg::mesi_t   state_transfer,
    // Coherence unit side
    output coh_pkg::addr_t   lookup_addr,
    input  coh_pkg::mesi_t   line_state,
    output logic             fill_valid,
    output logic             fill_exclusive,
    output logic             fill_write,
    output logic             write_hit,
    input  logic [IDX_W-1:0] invalidate_idx,
    input  logic             invalidate_strobe,
    input  coh_pkg::addr_t   snoop_addr,
    output coh_pkg::block_t  snoop_block,
    // Bus side
    output logic             d_ren,
    output logic             d_wen,
    output logic             cc_write,
    output coh_pkg::addr_t   d_addr,
    output coh_pkg::block_t  d_store,
    input  logic             d_wait,
    input  coh_pkg::block_t  d_load,
    input  logic             cc_exclusive
);

    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [TAG_W-1:0] tag_t;
    typedef enum logic [1:0] {
        IDLE,
        WB_VICTIM,  // Dirty victim goes out first
        MISS,
        UPGRADE     // S line needs exclusive ownership
    } cstate_t;

    cstate_t              state;
    coh_pkg::block_t      data_arr [NUM_LINES];
    tag_t                 tag_arr [NUM_LINES];
    logic [NUM_LINES-1:0] tag_valid;
    idx_t                 idx;
    tag_t                 tag;
    logic                 wsel;
    logic                 req;
    logic                 tag_match;
    logic                 hit;
    logic                 victim_dirty;
    coh_pkg::block_t      fill_block;

    // Address split: offset [1:0], word select [2], index, tag
    assign idx  = proc_addr[3 +: IDX_W];
    assign tag  = proc_addr[31 -: TAG_W];
    assign wsel = proc_addr[2];
    assign req  = proc_ren | proc_wen;

    assign lookup_addr  = proc_addr;  // State lookup follows the core
    assign tag_match    = tag_valid[idx] && (tag_arr[idx] == tag);
    assign hit          = tag_match && (line_state != coh_pkg::INVALID);
    // line_state belongs to the index, so a tag mismatch means it is the victim's
    assign victim_dirty = tag_valid[idx] && !tag_match && (line_state == coh_pkg::MODIFIED);

    // Writes on E or M complete locally
    assign write_hit = (state == IDLE) && proc_wen && hit &&
                       (line_state == coh_pkg::EXCLUSIVE || line_state == coh_pkg::MODIFIED);
    assign proc_busy = (state != IDLE) || (req && !(hit && proc_ren) && !write_hit);
    assign proc_rdata = data_arr[idx][32*wsel +: 32];
    assign state_transfer = write_hit ? coh_pkg::MODIFIED : line_state;

    assign d_ren    = (state == MISS);
    assign d_wen    = (state == WB_VICTIM);
    assign cc_write = (state == UPGRADE) || (state == MISS && proc_wen);  // Exclusive intent
    assign d_addr   = (state == WB_VICTIM) ? {tag_arr[idx], idx, 3'b000}
                                           : {tag, idx, 3'b000};
    assign d_store  = data_arr[idx];
    assign snoop_block = data_arr[snoop_addr[3 +: IDX_W]];  // Block the peer may supply

    // New state is reported on the cycle the bus releases d_wait
    assign fill_valid     = (state == MISS || state == UPGRADE) && !d_wait;
    assign fill_exclusive = cc_exclusive;
    assign fill_write     = proc_wen;

    // Pending store merged into the incoming block
    always_comb begin
        fill_block = d_load;
        if (proc_wen) begin
            fill_block[32*wsel +: 32] = proc_wdata;
        end
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (req && !hit) begin
                        state <= victim_dirty ? WB_VICTIM : MISS;
                    end else if (proc_wen && hit && !write_hit) begin
                        state <= UPGRADE;  // Line is S
                    end
                end
                WB_VICTIM: begin
                    if (!d_wait) state <= MISS;
                end
                MISS: begin
                    if (!d_wait) state <= IDLE;
                end
                UPGRADE: begin
                    if (!d_wait) begin
                        state <= IDLE;
                    end else if (!hit) begin
                        state <= MISS;  // Lost the line to the other core while waiting
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            tag_valid <= '0;
        end else begin
            if (invalidate_strobe) tag_valid[invalidate_idx] <= 1'b0;
            if (fill_valid) tag_valid[idx] <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (fill_valid && state == MISS) begin
            data_arr[idx] <= fill_block;
            tag_arr[idx]  <= tag;
        end else if (write_hit) begin
            data_arr[idx][32*wsel +: 32] <= proc_wdata;
        end
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run with Verilator, then look for the fail message in the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps -f all.f \
    --top-module tb_cache_coherency -Mdir obj_dir \
    && ./obj_dir/Vtb_cache_coherency | tee sim.log \
    || { echo "Build or simulation did not complete"; exit 1; }
grep -q "Errors found" sim.log && exit 1 || exit 0
